// ==== build.f ====
+incdir+include
logic/inflight_pkg.sv
logic/write_router.sv
logic/inflight_bank.sv
logic/read_merge.sv
logic/inflight_table.sv
tests/inflight_table_sva.sv
tests/tb_inflight_table.sv

// ==== include/inflight_macros.svh ====
`ifndef INFLIGHT_MACROS_SVH
`define INFLIGHT_MACROS_SVH

// register address split: low bits pick the bank, high bits the row
`define INFL_ADDR_BITS 6
`define INFL_BANK_BITS 2
`define INFL_ROW_BITS  4

// geometry
`define INFL_NUM_BANKS 4
`define INFL_NUM_ROWS  16

// port counts
`define INFL_NUM_READ  3
`define INFL_NUM_WB    2
`define INFL_NUM_ALLOC 2

`endif

// ==== logic/inflight_bank.sv ====
`include "inflight_macros.svh"

module inflight_bank
  import inflight_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  row_bits_t  clear_mask,
  input  row_bits_t  set_mask,
  input  row_t       read_row [`INFL_NUM_READ],
  output read_bits_t read_bit
);

  row_bits_t busy_bits;
  row_bits_t next_bits;

  // clear first, so a set on the same edge wins
  assign next_bits = (busy_bits & ~clear_mask) | set_mask;

  // rows hold their value while rst is high
  always_ff @(posedge clk)
  begin
    if (!rst)
      busy_bits <= next_bits;
  end

  genvar r;

  generate
    for (r = 0; r < `INFL_NUM_READ; r++)
    begin : g_read
      assign read_bit[r] = busy_bits[read_row[r]];
    end
  endgenerate

endmodule

// ==== logic/inflight_pkg.sv ====
`include "inflight_macros.svh"

package inflight_pkg;

  // full architectural register number
  typedef logic [`INFL_ADDR_BITS-1:0] reg_addr_t;

  typedef logic [`INFL_BANK_BITS-1:0] bank_idx_t;
  typedef logic [`INFL_ROW_BITS-1:0]  row_t;

  // one flag per row of a bank
  typedef logic [`INFL_NUM_ROWS-1:0] row_bits_t;

  // one bit per read port
  typedef logic [`INFL_NUM_READ-1:0] read_bits_t;

  typedef enum logic {INIT_CLEAR, INIT_RUN} init_state_t;

endpackage

// ==== logic/inflight_table.sv ====
`include "inflight_macros.svh"

module inflight_table
  import inflight_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        read_en,
  input  reg_addr_t                   read_addr [`INFL_NUM_READ],
  input  logic [`INFL_NUM_READ-1:0]   read_const,
  input  logic [`INFL_NUM_READ-1:0]   read_oe,
  input  reg_addr_t                   wb_addr [`INFL_NUM_WB],
  input  logic [`INFL_NUM_WB-1:0]     wb_en,
  input  reg_addr_t                   alloc_addr [`INFL_NUM_ALLOC],
  input  logic [`INFL_NUM_ALLOC-1:0]  alloc_en,
  output read_bits_t                  read_data,
  output logic                        init_busy
);

  row_bits_t                 clear_mask [`INFL_NUM_BANKS];
  row_bits_t                 set_mask [`INFL_NUM_BANKS];
  reg_addr_t                 wb_addr_dly [`INFL_NUM_WB];
  logic [`INFL_NUM_WB-1:0]   wb_en_dly;
  row_t                      read_row [`INFL_NUM_READ];
  read_bits_t                bank_bits [`INFL_NUM_BANKS];

  write_router i_router (
    .clk         (clk),
    .rst         (rst),
    .wb_addr     (wb_addr),
    .wb_en       (wb_en),
    .alloc_addr  (alloc_addr),
    .alloc_en    (alloc_en),
    .clear_mask  (clear_mask),
    .set_mask    (set_mask),
    .wb_addr_dly (wb_addr_dly),
    .wb_en_dly   (wb_en_dly),
    .init_busy   (init_busy)
  );

  genvar b;

  // all banks share the read rows, the merge picks the bank
  generate
    for (b = 0; b < `INFL_NUM_BANKS; b++)
    begin : g_bank
      inflight_bank i_bank (
        .clk        (clk),
        .rst        (rst),
        .clear_mask (clear_mask[b]),
        .set_mask   (set_mask[b]),
        .read_row   (read_row),
        .read_bit   (bank_bits[b])
      );
    end
  endgenerate

  read_merge i_merge (
    .clk         (clk),
    .rst         (rst),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .read_const  (read_const),
    .read_oe     (read_oe),
    .wb_addr     (wb_addr),
    .wb_en       (wb_en),
    .wb_addr_dly (wb_addr_dly),
    .wb_en_dly   (wb_en_dly),
    .init_busy   (init_busy),
    .bank_bits   (bank_bits),
    .read_row    (read_row),
    .read_data   (read_data)
  );

endmodule

// ==== logic/read_merge.sv ====
`include "inflight_macros.svh"

module read_merge
  import inflight_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     read_en,
  input  reg_addr_t                read_addr [`INFL_NUM_READ],
  input  logic [`INFL_NUM_READ-1:0] read_const,
  input  logic [`INFL_NUM_READ-1:0] read_oe,
  input  reg_addr_t                wb_addr [`INFL_NUM_WB],
  input  logic [`INFL_NUM_WB-1:0]   wb_en,
  input  reg_addr_t                wb_addr_dly [`INFL_NUM_WB],
  input  logic [`INFL_NUM_WB-1:0]   wb_en_dly,
  input  logic                     init_busy,
  input  read_bits_t               bank_bits [`INFL_NUM_BANKS],
  output row_t                     read_row [`INFL_NUM_READ],
  output read_bits_t               read_data
);

  reg_addr_t                 addr_q [`INFL_NUM_READ];
  logic [`INFL_NUM_READ-1:0] const_q;
  logic [`INFL_NUM_READ-1:0] oe_q;
  bank_idx_t                 bank_q [`INFL_NUM_READ];
  read_bits_t                sel_bit;
  read_bits_t                wb_hit;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      const_q <= '0;
      oe_q    <= '0;
    end
    else if (read_en)
    begin
      const_q <= read_const;
      // reads issued during start-up come back as 0
      oe_q    <= read_oe & {`INFL_NUM_READ{~init_busy}};
    end
  end

  always_ff @(posedge clk)
  begin
    if (read_en)
      addr_q <= read_addr;
  end

  genvar i;

  generate
    for (i = 0; i < `INFL_NUM_READ; i++)
    begin : g_port
      assign read_row[i] = addr_q[i][`INFL_ADDR_BITS-1:`INFL_BANK_BITS];
      assign bank_q[i]   = addr_q[i][`INFL_BANK_BITS-1:0];
      assign sel_bit[i]  = bank_bits[bank_q[i]][i];
    end
  endgenerate

  // write-first: a writeback in flight or arriving now reads as done
  always_comb
  begin
    wb_hit = '0;
    for (int p = 0; p < `INFL_NUM_READ; p++)
    begin
      for (int w = 0; w < `INFL_NUM_WB; w++)
      begin
        if (wb_en[w] && wb_addr[w] == addr_q[p])
          wb_hit[p] = 1'b1;
        if (wb_en_dly[w] && wb_addr_dly[w] == addr_q[p])
          wb_hit[p] = 1'b1;
      end
    end
  end

  assign read_data = sel_bit & oe_q & ~const_q & ~wb_hit;

endmodule

// ==== logic/write_router.sv ====
`include "inflight_macros.svh"

module write_router
  import inflight_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  reg_addr_t                   wb_addr [`INFL_NUM_WB],
  input  logic [`INFL_NUM_WB-1:0]     wb_en,
  input  reg_addr_t                   alloc_addr [`INFL_NUM_ALLOC],
  input  logic [`INFL_NUM_ALLOC-1:0]  alloc_en,
  output row_bits_t                   clear_mask [`INFL_NUM_BANKS],
  output row_bits_t                   set_mask [`INFL_NUM_BANKS],
  output reg_addr_t                   wb_addr_dly [`INFL_NUM_WB],
  output logic [`INFL_NUM_WB-1:0]     wb_en_dly,
  output logic                        init_busy
);

  init_state_t state;
  row_t        init_row;

  bank_idx_t wb_bank [`INFL_NUM_WB];
  row_t      wb_row [`INFL_NUM_WB];
  bank_idx_t alloc_bank [`INFL_NUM_ALLOC];
  row_t      alloc_row [`INFL_NUM_ALLOC];

  // start-up clear, one row of every bank per cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= INIT_CLEAR;
      init_row <= '0;
    end
    else if (state == INIT_CLEAR)
    begin
      init_row <= init_row + 1'b1;
      if (init_row == row_t'(`INFL_NUM_ROWS - 1))
        state <= INIT_RUN;
    end
  end

  assign init_busy = (state == INIT_CLEAR);

  // writeback delay stage
  always_ff @(posedge clk)
  begin
    if (rst)
      wb_en_dly <= '0;
    else
      wb_en_dly <= wb_en;
  end

  always_ff @(posedge clk)
  begin
    wb_addr_dly <= wb_addr;
  end

  genvar w;
  genvar a;

  generate
    for (w = 0; w < `INFL_NUM_WB; w++)
    begin : g_wb_split
      assign wb_bank[w] = wb_addr_dly[w][`INFL_BANK_BITS-1:0];
      assign wb_row[w]  = wb_addr_dly[w][`INFL_ADDR_BITS-1:`INFL_BANK_BITS];
    end
    for (a = 0; a < `INFL_NUM_ALLOC; a++)
    begin : g_alloc_split
      assign alloc_bank[a] = alloc_addr[a][`INFL_BANK_BITS-1:0];
      assign alloc_row[a]  = alloc_addr[a][`INFL_ADDR_BITS-1:`INFL_BANK_BITS];
    end
  endgenerate

  // per-bank decode, delayed writebacks clear and allocates set
  always_comb
  begin
    for (int b = 0; b < `INFL_NUM_BANKS; b++)
    begin
      clear_mask[b] = '0;
      set_mask[b]   = '0;
      if (state == INIT_CLEAR)
        clear_mask[b][init_row] = 1'b1;
      for (int i = 0; i < `INFL_NUM_WB; i++)
      begin
        if (wb_en_dly[i] && wb_bank[i] == bank_idx_t'(b))
          clear_mask[b][wb_row[i]] = 1'b1;
      end
      for (int j = 0; j < `INFL_NUM_ALLOC; j++)
      begin
        if (alloc_en[j] && alloc_bank[j] == bank_idx_t'(b))
          set_mask[b][alloc_row[j]] = 1'b1;
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the in-flight table testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

rm -rf obj_dir "$build_log" "$sim_log"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module tb_inflight_table -o tb_inflight_table \
  > "$build_log" 2>&1 \
  || { echo "compile failed, see $build_log"; exit 1; }

./obj_dir/tb_inflight_table > "$sim_log" 2>&1 \
  || echo "simulator exited with an error" >> "$sim_log"

grep -q "SOME TESTS FAILED" "$sim_log" && { echo "FAIL: see $sim_log"; exit 1; }
grep -q "ALL TESTS PASSED" "$sim_log" || { echo "FAIL: no result in $sim_log"; exit 1; }
echo "PASS"

// ==== tests/inflight_table_sva.sv ====
`include "inflight_macros.svh"

module inflight_table_sva
  import inflight_pkg::*;
(
  input logic                        clk,
  input logic                        rst,
  input logic                        init_busy,
  input logic [`INFL_NUM_ALLOC-1:0]  alloc_en,
  input logic                        read_en,
  input logic [`INFL_NUM_READ-1:0]   read_oe,
  input read_bits_t                  read_data
);
  timeunit 1ns;
  timeprecision 1ps;

  // output enable as captured by the last read
  read_bits_t oe_seen;

  always_ff @(posedge clk)
  begin
    if (rst)
      oe_seen <= '0;
    else if (read_en)
      oe_seen <= read_oe & {`INFL_NUM_READ{~init_busy}};
  end

  // start-up clear takes one cycle per row
  init_still_busy: assert property (@(posedge clk) $fell(rst) |-> ##15 init_busy)
    else $error("init_busy dropped before 16 cycles");

  init_done: assert property (@(posedge clk) $fell(rst) |-> ##16 !init_busy)
    else $error("init_busy still high 16 cycles after reset");

  no_alloc_in_init: assert property (@(posedge clk) disable iff (rst)
    init_busy |-> alloc_en == '0)
    else $error("allocate seen while init_busy is high");

  masked_by_oe: assert property (@(posedge clk) disable iff (rst)
    (read_data & ~oe_seen) == '0)
    else $error("read_data set on a port whose output enable was low");

endmodule

bind inflight_table inflight_table_sva i_sva (
  .clk       (clk),
  .rst       (rst),
  .init_busy (init_busy),
  .alloc_en  (alloc_en),
  .read_en   (read_en),
  .read_oe   (read_oe),
  .read_data (read_data)
);

// ==== tests/tb_inflight_table.sv ====
`include "inflight_macros.svh"

module tb_inflight_table
  import inflight_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 100;
  localparam int INIT_LIMIT  = 40;
  // reset, then the budget of each test in order
  localparam int RUN_CYCLES  = 4 + 30 + 32 + 8 + 6 + 44;
  localparam int WDOG_MARGIN = 50;

  logic                        clk;
  logic                        rst;
  logic                        read_en;
  reg_addr_t                   read_addr [`INFL_NUM_READ];
  logic [`INFL_NUM_READ-1:0]   read_const;
  logic [`INFL_NUM_READ-1:0]   read_oe;
  reg_addr_t                   wb_addr [`INFL_NUM_WB];
  logic [`INFL_NUM_WB-1:0]     wb_en;
  reg_addr_t                   alloc_addr [`INFL_NUM_ALLOC];
  logic [`INFL_NUM_ALLOC-1:0]  alloc_en;
  read_bits_t                  read_data;
  logic                        init_busy;

  // reference model, one in-flight bit per register
  logic [(1 << `INFL_ADDR_BITS)-1:0] model_bits;
  reg_addr_t                         alloc_list [$];
  reg_addr_t                         last_addr [`INFL_NUM_READ];
  logic [`INFL_NUM_READ-1:0]         last_const;
  logic [`INFL_NUM_READ-1:0]         last_oe;
  logic                              last_busy;
  int                                run_edges;
  integer                            seed;
  int                                errors;
  int                                checks;

  inflight_table i_dut (
    .clk        (clk),
    .rst        (rst),
    .read_en    (read_en),
    .read_addr  (read_addr),
    .read_const (read_const),
    .read_oe    (read_oe),
    .wb_addr    (wb_addr),
    .wb_en      (wb_en),
    .alloc_addr (alloc_addr),
    .alloc_en   (alloc_en),
    .read_data  (read_data),
    .init_busy  (init_busy)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk = ~clk;
  end

  // edges since reset released, the start-up clear owns the first rows count of them
  always @(posedge clk)
  begin
    if (rst)
      run_edges <= 0;
    else
      run_edges <= run_edges + 1;
  end

  initial
  begin
    #(CLK_PERIOD * (RUN_CYCLES + WDOG_MARGIN));
    $display("watchdog expired, run not finished after %0d cycles", RUN_CYCLES + WDOG_MARGIN);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic reg_addr_t random_reg();
    return reg_addr_t'($random(seed));
  endfunction

  // model bit, masked by constant, output enable and start-up
  function automatic read_bits_t expected_read();
    read_bits_t exp_data;
    for (int p = 0; p < `INFL_NUM_READ; p++)
      exp_data[p] = model_bits[last_addr[p]] & last_oe[p] & ~last_const[p] & ~last_busy;
    return exp_data;
  endfunction

  task automatic drive_idle();
    read_en  <= 1'b0;
    wb_en    <= '0;
    alloc_en <= '0;
  endtask

  // returns just after the edge that captures the read
  task automatic start_read(input reg_addr_t a0, input reg_addr_t a1, input reg_addr_t a2,
                            input logic [2:0] cst, input logic [2:0] oe);
    last_addr[0] = a0;
    last_addr[1] = a1;
    last_addr[2] = a2;
    last_const   = cst;
    last_oe      = oe;
    read_en    <= 1'b1;
    read_const <= cst;
    read_oe    <= oe;
    for (int p = 0; p < `INFL_NUM_READ; p++)
      read_addr[p] <= last_addr[p];
    @(negedge clk);
    // capture edge still inside the start-up clear
    last_busy = (run_edges < `INFL_NUM_ROWS);
    @(posedge clk);
    drive_idle();
  endtask

  task automatic check_read(input string name);
    read_bits_t exp_data;
    @(negedge clk);
    exp_data = expected_read();
    checks++;
    assert (read_data === exp_data)
    else
    begin
      $display("[ERROR] %s: expected %b, actual %b (regs %0d %0d %0d)", name, exp_data,
               read_data, last_addr[0], last_addr[1], last_addr[2]);
      errors++;
    end
  endtask

  task automatic read_check(input string name, input reg_addr_t a0, input reg_addr_t a1,
                            input reg_addr_t a2, input logic [2:0] cst, input logic [2:0] oe);
    start_read(a0, a1, a2, cst, oe);
    check_read(name);
    @(posedge clk);
  endtask

  task automatic alloc_pair(input reg_addr_t a0, input reg_addr_t a1, input logic [1:0] en);
    alloc_addr[0] <= a0;
    alloc_addr[1] <= a1;
    alloc_en      <= en;
    @(posedge clk);
    drive_idle();
    if (en[0])
    begin
      model_bits[a0] = 1'b1;
      alloc_list.push_back(a0);
    end
    if (en[1])
    begin
      model_bits[a1] = 1'b1;
      alloc_list.push_back(a1);
    end
    @(posedge clk);
  endtask

  task automatic writeback_pair(input reg_addr_t a0, input reg_addr_t a1, input logic [1:0] en);
    wb_addr[0] <= a0;
    wb_addr[1] <= a1;
    wb_en      <= en;
    // done as soon as presented
    if (en[0])
      model_bits[a0] = 1'b0;
    if (en[1])
      model_bits[a1] = 1'b0;
    @(posedge clk);
    drive_idle();
    @(posedge clk);
  endtask

  task automatic test_after_init();
    int cycles;
    read_check("read_during_init", random_reg(), random_reg(), random_reg(), 3'b000, 3'b111);
    cycles = 0;
    @(negedge clk);
    while (init_busy && cycles < INIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    checks++;
    assert (!init_busy)
    else
    begin
      $display("init_busy still high %0d cycles after the start-up read", INIT_LIMIT);
      errors++;
    end
    @(posedge clk);
    for (int k = 0; k < 2; k++)
      read_check("zero_after_init", random_reg(), random_reg(), random_reg(), 3'b000, 3'b111);
  endtask

  task automatic test_alloc_read();
    reg_addr_t free_regs [`INFL_NUM_READ];
    int        n;
    for (int k = 0; k < 4; k++)
      alloc_pair(random_reg(), random_reg(), 2'b11);
    repeat (2) @(posedge clk);
    n = alloc_list.size();
    // every allocated register passes through every port
    for (int k = 0; k < n; k++)
      read_check("alloc_read", alloc_list[k], alloc_list[(k + 1) % n],
                 alloc_list[(k + 2) % n], 3'b000, 3'b111);
    for (int p = 0; p < `INFL_NUM_READ; p++)
    begin
      free_regs[p] = random_reg();
      while (model_bits[free_regs[p]])
        free_regs[p] = random_reg();
    end
    read_check("free_read", free_regs[0], free_regs[1], free_regs[2], 3'b000, 3'b111);
  endtask

  task automatic test_wb_bypass();
    reg_addr_t done_reg;
    reg_addr_t live_reg;
    done_reg = alloc_list[0];
    live_reg = alloc_list[1];
    for (int k = 1; k < alloc_list.size(); k++)
      if (alloc_list[k] != done_reg)
        live_reg = alloc_list[k];
    start_read(done_reg, live_reg, done_reg, 3'b000, 3'b111);
    // writeback shows up while the captured read is held
    wb_addr[0] <= done_reg;
    wb_en      <= 2'b01;
    model_bits[done_reg] = 1'b0;
    check_read("wb_bypass_current");
    @(posedge clk);
    drive_idle();
    check_read("wb_bypass_delayed");
    @(posedge clk);
    check_read("wb_written");
    @(posedge clk);
  endtask

  task automatic test_const_oe();
    reg_addr_t busy_reg;
    busy_reg = alloc_list[0];
    foreach (alloc_list[k])
      if (model_bits[alloc_list[k]])
        busy_reg = alloc_list[k];
    read_check("const_flag", busy_reg, busy_reg, busy_reg, 3'b101, 3'b111);
    read_check("oe_low", busy_reg, busy_reg, busy_reg, 3'b000, 3'b010);
  endtask

  // each operation is followed by an idle cycle
  task automatic test_random_mix();
    int        kind;
    reg_addr_t pick;
    for (int op = 0; op < 20; op++)
    begin
      kind = $unsigned($random(seed)) % 3;
      pick = alloc_list[$unsigned($random(seed)) % alloc_list.size()];
      case (kind)
        0: alloc_pair(random_reg(), random_reg(), 2'($random(seed)) | 2'b01);
        1: writeback_pair(pick, random_reg(), 2'($random(seed)) | 2'b01);
        default: read_check("random_mix", pick, random_reg(), random_reg(),
                            3'($random(seed) & $random(seed)),
                            3'($random(seed) | $random(seed)));
      endcase
    end
  endtask

  initial
  begin
    seed       = 32'he209_cbe7;
    errors     = 0;
    checks     = 0;
    model_bits = '0;
    rst        = 1'b1;
    read_en    = 1'b0;
    read_const = '0;
    read_oe    = '0;
    wb_en      = '0;
    alloc_en   = '0;
    for (int p = 0; p < `INFL_NUM_READ; p++)
      read_addr[p] = '0;
    for (int w = 0; w < `INFL_NUM_WB; w++)
      wb_addr[w] = '0;
    for (int a = 0; a < `INFL_NUM_ALLOC; a++)
      alloc_addr[a] = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_after_init();
    test_alloc_read();
    test_wb_bypass();
    test_const_oe();
    test_random_mix();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
